// File: include/ppu_config.svh
/*
 * Global size macros for the pixel fetch path
 * Bus word, widest pixel, word address and palette depth
 */

`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

// Width of one word on the external memory bus
`define PPU_W_DATA 16

// Widest pixel the streamer can present, used by the ARGB1555 mode
`define PPU_W_PIX_MAX 16

// Word address width on the memory bus
`define PPU_W_ADDR 16

// Number of colour entries in the host-written palette
`define PPU_PAL_SIZE 256

`endif

// File: design/ppu_pkg.sv
/*
 * Shared types of the pixel fetch path
 * Width typedefs, pixel mode enum, output pixel and span structs
 */

`default_nettype none

`include "ppu_config.svh"

package ppu_pkg;

	// One word as read from the memory bus
	typedef logic [`PPU_W_DATA-1:0] bus_word_t;

	// Word address on the memory bus
	typedef logic [`PPU_W_ADDR-1:0] bus_addr_t;

	// Bit position inside one bus word
	typedef logic [$clog2(`PPU_W_DATA)-1:0] bit_offset_t;

	// Index into the palette
	typedef logic [$clog2(`PPU_PAL_SIZE)-1:0] pal_index_t;

	// Five bits each of red, green and blue
	typedef logic [14:0] rgb555_t;

	// Paletted modes all have bit 2 set, and their low two bits give 3 - log2(pixel size)
	typedef enum logic [2:0] {
		mode_argb1555 = 3'b000,
		mode_pal8     = 3'b100,
		mode_pal4     = 3'b101,
		mode_pal2     = 3'b110,
		mode_pal1     = 3'b111
	} pixel_mode_t;

	// Final pixel as delivered on the output handshake
	typedef struct packed {
		logic    alpha;
		rgb555_t rgb;
	} pixel_t;

	// Everything the host supplies with a flush strobe
	typedef struct packed {
		bus_addr_t   base_addr;
		bit_offset_t bit_offset;
		pixel_mode_t pixel_mode;
		logic [3:0]  palette_offset;
	} span_cfg_t;

endpackage

`default_nettype wire

// File: design/pixel_gearbox.sv
/*
 * Loadable right-shift register for pixel extraction
 * Shift amounts are powers of two from 1 to 16 bits
 */

`default_nettype none

`include "ppu_config.svh"

module ppu_pixel_gearbox
	import ppu_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,
	input  wire bus_word_t din,
	input  wire            din_vld,
	input  wire [2:0]      shamt,
	output logic [`PPU_W_PIX_MAX-1:0] dout
);

	// Holds the unconsumed part of the current bus word
	bus_word_t sreg;

	// Shift code n moves the word right by 2**(n-1) bits, code 0 holds
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sreg <= '0;
		end else if (din_vld) begin
			// A fresh word always wins over a shift in the same cycle
			sreg <= din;
		end else begin
			case (shamt)
				3'd1: begin
					sreg <= sreg >> 1;
				end
				3'd2: begin
					sreg <= sreg >> 2;
				end
				3'd3: begin
					sreg <= sreg >> 4;
				end
				3'd4: begin
					sreg <= sreg >> 8;
				end
				3'd5: begin
					// Whole word consumed, as in ARGB1555 mode
					sreg <= sreg >> 16;
				end
				default: begin
					sreg <= sreg;
				end
			endcase
		end
	end

	// The current pixel always sits at the bottom of the register
	assign dout = sreg[`PPU_W_PIX_MAX-1:0];

endmodule

`default_nettype wire

// File: design/pixel_streamer.sv
/*
 * Pixel streamer with shift position tracking and post-flush seek
 * Requests bus words and presents masked, offset palette indices
 */

`default_nettype none

`include "ppu_config.svh"

module ppu_pixel_streamer
	import ppu_pkg::*;
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              flush,
	input  wire bit_offset_t seek_target,
	input  wire pixel_mode_t pixel_mode,
	input  wire [3:0]        palette_offset,
	output logic             load_req,
	input  wire              load_ack,
	input  wire bus_word_t   load_data,
	output logic [`PPU_W_PIX_MAX-1:0] idx,
	output logic             alpha,
	output logic             idx_vld,
	input  wire              idx_rdy
);

	localparam int W_CTR = $bits(bit_offset_t);

	logic                      active;
	bit_offset_t               shift_ctr;
	logic                      shift_empty;
	logic                      shift_seeking;
	bit_offset_t               seek_tgt;
	logic [2:0]                log_size;
	logic [W_CTR:0]            pix_size;
	logic [W_CTR:0]            ctr_sum;
	bit_offset_t               seek_amt;
	logic                      seek_end;
	logic [2:0]                seek_code;
	logic                      xfer;
	logic                      shift_en;
	logic [2:0]                gear_shamt;
	logic [`PPU_W_PIX_MAX-1:0] shift_out;
	logic [7:0]                pal_mask;
	logic [7:0]                idx_masked;

	// Paletted modes give 3 - mode[1:0], ARGB1555 always takes 16 bits
	assign log_size = pixel_mode[2] ? 3'd3 - {1'b0, pixel_mode[1:0]} : 3'd4;
	assign pix_size = (W_CTR + 1)'(1) << log_size;

	// The carry out of this sum means the word is used up
	assign ctr_sum = {1'b0, shift_ctr} + pix_size;

	// During seek the counter holds a one-hot marker walking down from the top bit
	assign seek_amt = seek_tgt & shift_ctr;

	// Seek stops once no target bits remain below the marker
	assign seek_end = ~|(seek_tgt & (shift_ctr - 1'b1));

	// Marker position to gearbox shift code
	always_comb begin
		seek_code = '0;
		for (int i = 0; i < W_CTR; i++) begin
			if (seek_amt[i]) begin
				seek_code = 3'(i + 1);
			end
		end
	end

	assign xfer = idx_vld && idx_rdy;
	assign shift_en = xfer || (shift_seeking && !shift_empty && |seek_amt);

	// Steady state shifts by one pixel, seek by the marker weight
	always_comb begin
		if (!shift_en) begin
			gear_shamt = 3'd0;
		end else if (shift_seeking) begin
			gear_shamt = seek_code;
		end else begin
			gear_shamt = log_size + 3'd1;
		end
	end

	ppu_pixel_gearbox gearbox_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.din     (load_data),
		.din_vld (load_ack),
		.shamt   (gear_shamt),
		.dout    (shift_out)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active        <= 1'b0;
			shift_ctr     <= '0;
			shift_empty   <= 1'b1;
			shift_seeking <= 1'b0;
			seek_tgt      <= '0;
		end else if (flush) begin
			// Any partial word is dropped, an unaligned span starts with the marker on top
			active        <= 1'b1;
			shift_ctr     <= {|seek_target, {(W_CTR - 1){1'b0}}};
			shift_empty   <= 1'b1;
			shift_seeking <= |seek_target;
			seek_tgt      <= seek_target;
		end else if (shift_empty) begin
			shift_empty <= !load_ack;
		end else if (shift_seeking) begin
			shift_seeking <= !seek_end;
			// After the last seek step the counter lands on the real bit position
			shift_ctr <= seek_end ? seek_tgt : shift_ctr >> 1;
		end else if (xfer) begin
			shift_empty <= ctr_sum[W_CTR];
			shift_ctr   <= ctr_sum[W_CTR-1:0];
		end
	end

	// Keep only the bits that belong to the current pixel
	always_comb begin
		case (pixel_mode)
			mode_pal1: pal_mask = 8'h01;
			mode_pal2: pal_mask = 8'h03;
			mode_pal4: pal_mask = 8'h0f;
			default:   pal_mask = 8'hff;
		endcase
	end

	assign idx_masked = shift_out[7:0] & pal_mask;

	// Direct colour pixels pass untouched, paletted ones get the offset in bits 7:4
	assign idx = pixel_mode[2] ?
		{shift_out[`PPU_W_PIX_MAX-1:8], idx_masked | {palette_offset, 4'h0}} : shift_out;

	// Index zero is transparent, before the offset is applied
	assign alpha = pixel_mode[2] ? |idx_masked : shift_out[15];

	// No request until the host has started a span
	assign load_req = active && shift_empty;
	assign idx_vld = !shift_empty && !shift_seeking;

endmodule

`default_nettype wire

// File: design/pixel_fetch.sv
/*
 * Word address counter and memory bus master
 * One outstanding read, driven by the streamer's load request
 */

`default_nettype none

`include "ppu_config.svh"

module ppu_pixel_fetch
	import ppu_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,
	input  wire            flush,
	input  wire bus_addr_t base_addr,
	input  wire            load_req,
	output logic           load_ack,
	output bus_word_t      load_data,
	output logic           bus_req,
	output bus_addr_t      bus_addr,
	input  wire            bus_ack,
	input  wire bus_word_t bus_rdata
);

	// Address of the next word to read
	bus_addr_t addr_q;

	// Flush wins over a coinciding acknowledge, so the new span restarts at its base
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q <= '0;
		end else if (flush) begin
			addr_q <= base_addr;
		end else if (bus_ack) begin
			// Each completed read moves on to the following word
			addr_q <= addr_q + 1'b1;
		end
	end

	// The request level stays up until the streamer sees the acknowledge,
	// and the address only changes on that same edge
	assign bus_req  = load_req;
	assign bus_addr = addr_q;

	// Read data is only meaningful in the acknowledge cycle
	assign load_ack  = bus_ack;
	assign load_data = bus_rdata;

endmodule

`default_nettype wire

// File: design/palette_lookup.sv
/*
 * Host-written RGB555 palette with a one-entry output register
 * Paletted indices are looked up, ARGB1555 passes straight through
 */

`default_nettype none

`include "ppu_config.svh"

module ppu_palette_lookup
	import ppu_pkg::*;
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              flush,
	input  wire pixel_mode_t pixel_mode,
	input  wire              pal_wen,
	input  wire pal_index_t  pal_waddr,
	input  wire rgb555_t     pal_wdata,
	input  wire [`PPU_W_PIX_MAX-1:0] idx,
	input  wire              alpha,
	input  wire              idx_vld,
	output logic             idx_rdy,
	output pixel_t           pix,
	output logic             pix_vld,
	input  wire              pix_rdy
);

	rgb555_t pal_mem [`PPU_PAL_SIZE];
	rgb555_t colour;
	logic    accept;

	// Host writes land on the clock edge, so later lookups see them
	always_ff @(posedge clk) begin
		if (pal_wen) begin
			pal_mem[pal_waddr] <= pal_wdata;
		end
	end

	// The lookup happens as the index enters the stage, so a held pixel
	// cannot change under a palette write
	assign colour = pixel_mode[2] ? pal_mem[idx[7:0]] : idx[14:0];

	// Stage can take a new index when empty or when its pixel leaves this cycle
	assign idx_rdy = !pix_vld || pix_rdy;
	assign accept  = idx_vld && idx_rdy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_vld <= 1'b0;
		end else if (flush) begin
			// Drop whatever belonged to the previous span
			pix_vld <= 1'b0;
		end else if (accept) begin
			pix_vld <= 1'b1;
		end else if (pix_rdy) begin
			pix_vld <= 1'b0;
		end
	end

	// Pixel payload only moves on accept and stays put while stalled
	always_ff @(posedge clk) begin
		if (accept) begin
			pix.alpha <= alpha;
			pix.rgb   <= colour;
		end
	end

endmodule

`default_nettype wire

// File: design/ppu_pixel_pipe.sv
/*
 * Top level of the pixel fetch path
 * Fetch, streamer and palette lookup with per-span mode registers
 */

`default_nettype none

`include "ppu_config.svh"

module ppu_pixel_pipe
	import ppu_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,
	input  wire            flush,
	input  wire span_cfg_t span,
	output logic           bus_req,
	output bus_addr_t      bus_addr,
	input  wire            bus_ack,
	input  wire bus_word_t bus_rdata,
	input  wire            pal_wen,
	input  wire pal_index_t pal_waddr,
	input  wire rgb555_t   pal_wdata,
	output pixel_t         pix,
	output logic           pix_vld,
	input  wire            pix_rdy
);

	pixel_mode_t               span_mode;
	logic [3:0]                span_pal_offset;
	logic                      load_req;
	logic                      load_ack;
	bus_word_t                 load_data;
	logic [`PPU_W_PIX_MAX-1:0] idx;
	logic                      alpha;
	logic                      idx_vld;
	logic                      idx_rdy;

	// Mode and palette offset are only presented with the flush strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			span_mode       <= mode_argb1555;
			span_pal_offset <= 4'h0;
		end else if (flush) begin
			span_mode       <= span.pixel_mode;
			span_pal_offset <= span.palette_offset;
		end
	end

	// Base address and bit offset are captured inside the blocks at flush
	ppu_pixel_fetch fetch_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.base_addr (span.base_addr),
		.load_req  (load_req),
		.load_ack  (load_ack),
		.load_data (load_data),
		.bus_req   (bus_req),
		.bus_addr  (bus_addr),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata)
	);

	ppu_pixel_streamer streamer_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (flush),
		.seek_target    (span.bit_offset),
		.pixel_mode     (span_mode),
		.palette_offset (span_pal_offset),
		.load_req       (load_req),
		.load_ack       (load_ack),
		.load_data      (load_data),
		.idx            (idx),
		.alpha          (alpha),
		.idx_vld        (idx_vld),
		.idx_rdy        (idx_rdy)
	);

	ppu_palette_lookup lookup_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.pixel_mode (span_mode),
		.pal_wen    (pal_wen),
		.pal_waddr  (pal_waddr),
		.pal_wdata  (pal_wdata),
		.idx        (idx),
		.alpha      (alpha),
		.idx_vld    (idx_vld),
		.idx_rdy    (idx_rdy),
		.pix        (pix),
		.pix_vld    (pix_vld),
		.pix_rdy    (pix_rdy)
	);

endmodule

`default_nettype wire

// File: testbench/tb_ppu_pixel_pipe.sv
/*
 * Directed testbench for the pixel fetch path
 * Memory model, reference model, compare tasks, tests and watchdog
 */

`default_nettype none

`include "ppu_config.svh"

module tb_ppu_pixel_pipe
	import ppu_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int MEM_AW = 12;
	localparam int MAX_PIXELS = 1024;
	// Sum of the pixel counts of all the tests below
	localparam int TOTAL_PIXELS = 608;
	// Worst case for one pixel, covering a full word fetch and random stalls
	localparam int CYCLES_PER_PIXEL = 40;
	localparam logic [31:0] SEED = 32'h5523_cc80;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        flush;
	span_cfg_t   span;
	logic        bus_req;
	bus_addr_t   bus_addr;
	logic        bus_ack = 1'b0;
	bus_word_t   bus_rdata = '0;
	logic        pal_wen;
	pal_index_t  pal_waddr;
	rgb555_t     pal_wdata;
	pixel_t      pix;
	logic        pix_vld;
	logic        pix_rdy = 1'b0;

	bus_word_t   mem [1 << MEM_AW];
	rgb555_t     pal_ref [`PPU_PAL_SIZE];
	pixel_t      exp_pix [MAX_PIXELS];
	int          exp_count = 0;
	int          rx_count = 0;
	int          rx_next;
	logic        held = 1'b0;
	pixel_t      held_pix;
	logic        stall_en = 1'b0;
	logic        spans_started = 1'b0;
	bus_addr_t   exp_addr = '0;
	logic [1:0]  lat_left = 2'd0;
	logic [31:0] fill_state = SEED;
	logic [31:0] lat_state = SEED;
	logic [31:0] stall_state = SEED;

	always #(CLK_PERIOD / 2) clk = ~clk;

	ppu_pixel_pipe ppu_pixel_pipe_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.span      (span),
		.bus_req   (bus_req),
		.bus_addr  (bus_addr),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.pal_wen   (pal_wen),
		.pal_waddr (pal_waddr),
		.pal_wdata (pal_wdata),
		.pix       (pix),
		.pix_vld   (pix_vld),
		.pix_rdy   (pix_rdy)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_run();
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		stop_run();
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t want);
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input bus_addr_t got, input bus_addr_t want);
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			stop_run();
		end
	endtask

	// Pixel width in bits for each mode
	function automatic int pixel_bits(input pixel_mode_t mode);
		case (mode)
			mode_pal8: return 8;
			mode_pal4: return 4;
			mode_pal2: return 2;
			mode_pal1: return 1;
			default:   return 16;
		endcase
	endfunction

	// Pixel k of a span, taken LSB first from the memory contents
	function automatic pixel_t expected_pixel(input span_cfg_t cfg, input int k);
		int         size;
		int         pos;
		bus_addr_t  addr;
		bus_word_t  word;
		logic [7:0] raw;
		pal_index_t index;
		pixel_t     p;
		size = pixel_bits(cfg.pixel_mode);
		pos  = int'(cfg.bit_offset) + k * size;
		addr = cfg.base_addr + bus_addr_t'(pos / `PPU_W_DATA);
		word = mem[addr[MEM_AW-1:0]];
		if (cfg.pixel_mode == mode_argb1555) begin
			p.alpha = word[15];
			p.rgb   = word[14:0];
		end else begin
			raw     = 8'((word >> (pos % `PPU_W_DATA)) & bus_word_t'((1 << size) - 1));
			index   = raw | {cfg.palette_offset, 4'h0};
			// Transparency looks at the pixel bits alone, not at the offset
			p.alpha = (raw != 8'h00);
			p.rgb   = pal_ref[index];
		end
		return p;
	endfunction

	function automatic span_cfg_t make_span(input bus_addr_t base, input bit_offset_t offset,
			input pixel_mode_t mode, input logic [3:0] pal_offset);
		span_cfg_t cfg;
		cfg.base_addr      = base;
		cfg.bit_offset     = offset;
		cfg.pixel_mode     = mode;
		cfg.palette_offset = pal_offset;
		return cfg;
	endfunction

	// Memory answers each request after 0 to 3 extra cycles and checks the address order
	always @(posedge clk) begin
		if (!rst_n) begin
			bus_ack  <= 1'b0;
			lat_left <= 2'd0;
		end else begin
			if (bus_ack) begin
				bus_ack <= 1'b0;
			end else if (bus_req) begin
				if (lat_left == 2'd0) begin
					check_addr("bus_addr", bus_addr, exp_addr);
					lat_state = lcg_next(lat_state);
					bus_rdata <= mem[bus_addr[MEM_AW-1:0]];
					bus_ack   <= 1'b1;
					exp_addr  <= exp_addr + 16'd1;
					lat_left  <= lat_state[31:30];
				end else begin
					lat_left <= lat_left - 2'd1;
				end
			end
			// A new span restarts the expected address at its base
			if (flush) begin
				exp_addr <= span.base_addr;
			end
		end
	end

	// Output monitor compares each transfer and drives pix_rdy
	always @(posedge clk) begin
		if (!rst_n) begin
			pix_rdy <= 1'b0;
			held    <= 1'b0;
		end else begin
			stall_state = lcg_next(stall_state);
			// A stalled pixel has to be unchanged one cycle later
			if (pix_vld && held) begin
				check_pixel("pix while stalled", pix, held_pix);
			end
			rx_next = rx_count;
			if (pix_vld && pix_rdy) begin
				check_pixel($sformatf("pix[%0d]", rx_count), pix, exp_pix[rx_count]);
				rx_next = rx_count + 1;
			end
			rx_count <= rx_next;
			held     <= pix_vld && !pix_rdy;
			held_pix <= pix;
			// Ready only while pixels are still owed, with random gaps when enabled
			pix_rdy  <= (rx_next < exp_count) && (!stall_en || stall_state[31:30] != 2'b00);
		end
	end

	task automatic fill_memory();
		for (int i = 0; i < (1 << MEM_AW); i++) begin
			fill_state = lcg_next(fill_state);
			mem[i] = fill_state[31:16];
		end
		// Zero bytes inside the PAL8 span give transparent pixels
		mem[12'h202] = 16'h5a00;
		mem[12'h205] = 16'h0000;
	endtask

	task automatic load_palette();
		rgb555_t colour;
		for (int i = 0; i < `PPU_PAL_SIZE; i++) begin
			fill_state = lcg_next(fill_state);
			colour = fill_state[30:16];
			@(posedge clk);
			pal_wen   <= 1'b1;
			pal_waddr <= pal_index_t'(i);
			pal_wdata <= colour;
			pal_ref[i] = colour;
		end
		@(posedge clk);
		pal_wen <= 1'b0;
	endtask

	// Flush only once the DUT is frozen with no read pending
	task automatic start_span(input span_cfg_t cfg);
		do begin
			@(posedge clk);
		end while (bus_req || pix_rdy || (spans_started && !pix_vld));
		span  <= cfg;
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		spans_started = 1'b1;
	endtask

	task automatic run_span(input span_cfg_t cfg, input int count);
		start_span(cfg);
		@(negedge clk);
		for (int k = 0; k < count; k++) begin
			exp_pix[exp_count] = expected_pixel(cfg, k);
			exp_count++;
		end
		do begin
			@(posedge clk);
		end while (rx_count != exp_count);
	endtask

	task automatic test_argb_aligned();
		run_span(make_span(16'h0100, 4'd0, mode_argb1555, 4'h0), 24);
	endtask

	task automatic test_pal8();
		run_span(make_span(16'h0200, 4'd0, mode_pal8, 4'h0), 40);
	endtask

	task automatic test_pal_offsets();
		run_span(make_span(16'h0300, 4'd0, mode_pal4, 4'h3), 32);
		run_span(make_span(16'h0340, 4'd0, mode_pal2, 4'h9), 40);
		run_span(make_span(16'h0380, 4'd0, mode_pal1, 4'hf), 40);
	endtask

	// Each offset exercises a different set of seek steps
	task automatic test_unaligned();
		run_span(make_span(16'h0400, 4'd8, mode_pal8, 4'h1), 20);
		run_span(make_span(16'h0420, 4'd12, mode_pal4, 4'h6), 20);
		run_span(make_span(16'h0440, 4'd6, mode_pal2, 4'ha), 24);
		run_span(make_span(16'h0460, 4'd13, mode_pal1, 4'h4), 30);
	endtask

	task automatic test_stall_random();
		stall_en = 1'b1;
		run_span(make_span(16'h0500, 4'd0, mode_pal2, 4'h5), 300);
		stall_en = 1'b0;
	endtask

	// Each span stops while its next pixel still waits at the output,
	// and the following flush brings a new base and mode
	task automatic test_flush_mid_span();
		run_span(make_span(16'h0600, 4'd4, mode_pal4, 4'h2), 6);
		run_span(make_span(16'h0700, 4'd0, mode_argb1555, 4'h0), 12);
		run_span(make_span(16'h0720, 4'd3, mode_pal1, 4'hc), 20);
	endtask

	initial begin
		rst_n     = 1'b0;
		flush     = 1'b0;
		span      = '0;
		pal_wen   = 1'b0;
		pal_waddr = '0;
		pal_wdata = '0;
		fill_memory();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		load_palette();
		test_argb_aligned();
		test_pal8();
		test_pal_offsets();
		test_unaligned();
		test_stall_random();
		test_flush_mid_span();
		$display("=== PASS ===");
		$finish;
	end

	// Palette writes and reset are counted as pixels in the bound
	initial begin
		#((TOTAL_PIXELS + `PPU_PAL_SIZE + 16) * CYCLES_PER_PIXEL * CLK_PERIOD);
		report_error("Timeout: the DUT did not deliver all expected pixels in time");
	end

endmodule

`default_nettype wire

// File: ppu_pixel_pipe.f
+incdir+include
design/ppu_pkg.sv
design/pixel_gearbox.sv
design/pixel_streamer.sv
design/pixel_fetch.sv
design/palette_lookup.sv
design/ppu_pixel_pipe.sv
testbench/tb_ppu_pixel_pipe.sv

// File: Makefile
SRCS = ppu_pixel_pipe.f include/ppu_config.svh design/ppu_pkg.sv design/pixel_gearbox.sv \
	design/pixel_streamer.sv design/pixel_fetch.sv design/palette_lookup.sv \
	design/ppu_pixel_pipe.sv testbench/tb_ppu_pixel_pipe.sv

.PHONY: all run clean

all: obj_dir/Vtb_ppu_pixel_pipe

# Rebuilt only when one of the sources or the file list changes
obj_dir/Vtb_ppu_pixel_pipe: $(SRCS)
	verilator --binary --timing -Wno-fatal -f ppu_pixel_pipe.f --top-module tb_ppu_pixel_pipe

# The log decides the result, so a missing pass line fails the target
run: obj_dir/Vtb_ppu_pixel_pipe
	./obj_dir/Vtb_ppu_pixel_pipe | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
